// ==== source/cpu_pkg.sv ====
// widths, opcodes, alu operations, stage payload and port structs for the core
package cpu_pkg;

    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = '0;

    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [2:0]  f3_dword    = 3'b011;       // ld / sd width
    localparam logic [31:0] inst_ebreak = 32'h0010_0073;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b      // lui and jal link value
    } alu_op_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
        logic [xlen-1:0]       store_data;
        alu_op_e               alu_op;
        logic                  reg_wen;
        logic [reg_addr_w-1:0] rd;
        logic                  is_load;
        logic                  is_store;
        logic                  is_halt;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       alu_res;
        logic [xlen-1:0]       store_data;
        logic                  reg_wen;
        logic [reg_addr_w-1:0] rd;
        logic                  is_load;
        logic                  is_store;
        logic                  is_halt;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       wdata;
        logic                  reg_wen;
        logic [reg_addr_w-1:0] rd;
        logic                  is_halt;
    } mem_wb_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;
        logic                  reg_wen;
    } retire_t;

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_wen;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
        logic                  is_load;   // value is an address, data not yet back
    } fwd_t;

endpackage

// ==== source/stage_reg.sv ====
// pipeline register with stall hold and flush to bubble, typed by its payload
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;                  // bubble, valid low
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

// ==== source/if_stage.sv ====
// program counter, halt latch and instruction fetch port
`timescale 1ns/10ps

module if_stage (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     stall_i,
    input  logic                     halt_i,
    input  logic                     redirect_i,
    input  logic [cpu_pkg::xlen-1:0] target_i,
    output logic [cpu_pkg::xlen-1:0] imem_addr_o,
    input  logic [31:0]              imem_data_i,
    output cpu_pkg::if_id_t          if_id_o
);
    import cpu_pkg::*;

    logic [xlen-1:0] pc_q;
    logic            halted_q;
    logic            freeze;

    assign freeze = halt_i || halted_q;   // ebreak in decode or already halted

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q     <= reset_pc;
            halted_q <= 1'b0;
        end else begin
            if (halt_i) begin
                halted_q <= 1'b1;         // sticky until reset
            end
            if (!freeze && !stall_i) begin
                pc_q <= redirect_i ? target_i : pc_q + xlen'(4);
            end
        end
    end

    assign imem_addr_o  = pc_q;
    assign if_id_o.pc   = pc_q;
    assign if_id_o.inst = freeze ? '0 : imem_data_i;   // zero word decodes as bubble

endmodule

// ==== source/reg_file.sv ====
// 32 x 64-bit register file, x0 reads zero, same-cycle write bypass
`timescale 1ns/10ps

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic [cpu_pkg::reg_addr_w-1:0] ra1_i,
    input  logic [cpu_pkg::reg_addr_w-1:0] ra2_i,
    output logic [cpu_pkg::xlen-1:0]       rd1_o,
    output logic [cpu_pkg::xlen-1:0]       rd2_o,
    input  logic                           we_i,
    input  logic [cpu_pkg::reg_addr_w-1:0] wa_i,
    input  logic [cpu_pkg::xlen-1:0]       wd_i
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [1 << reg_addr_w];
    logic            wr_en;

    assign wr_en = we_i && (wa_i != '0);   // x0 never written

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wa_i] <= wd_i;
        end
    end

    assign rd1_o = (ra1_i == '0)              ? '0   :
                   (wr_en && (wa_i == ra1_i)) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0)              ? '0   :
                   (wr_en && (wa_i == ra2_i)) ? wd_i : regs[ra2_i];

endmodule

// ==== source/id_stage.sv ====
// decode, operand forwarding, load-use detection and branch/jal resolution
`timescale 1ns/10ps

module id_stage (
    input  cpu_pkg::if_id_t                if_id_i,
    output logic [cpu_pkg::reg_addr_w-1:0] rs1_o,
    output logic [cpu_pkg::reg_addr_w-1:0] rs2_o,
    input  logic [cpu_pkg::xlen-1:0]       rd1_i,
    input  logic [cpu_pkg::xlen-1:0]       rd2_i,
    input  cpu_pkg::fwd_t                  ex_fwd_i,
    input  cpu_pkg::fwd_t                  mem_fwd_i,
    output cpu_pkg::id_ex_t                id_ex_o,
    output logic                           ld_stall_o,
    output logic                           redirect_o,
    output logic [cpu_pkg::xlen-1:0]       target_o
);
    import cpu_pkg::*;

    logic [31:0]           inst;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [xlen-1:0]       src1, src2;
    logic                  use_rs1, use_rs2, is_beq, is_bne, is_jal, taken;
    logic                  dec_valid, dec_wen, dec_load, dec_store, dec_halt;
    alu_op_e               dec_op;
    logic [xlen-1:0]       dec_op_b;

    function automatic logic fwd_hit(fwd_t f, logic [reg_addr_w-1:0] rs);
        return f.valid && f.reg_wen && (f.rd == rs) && (rs != '0);
    endfunction

    function automatic logic [xlen-1:0] fwd_val(logic [reg_addr_w-1:0] rs,
                                                logic [xlen-1:0] rf_val,
                                                fwd_t ex, fwd_t mem);
        if (fwd_hit(ex, rs)) return ex.value;     // youngest result first
        if (fwd_hit(mem, rs)) return mem.value;
        return rf_val;
    endfunction

    assign inst   = if_id_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1_o  = inst[19:15];
    assign rs2_o  = inst[24:20];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign src1 = fwd_val(rs1_o, rd1_i, ex_fwd_i, mem_fwd_i);
    assign src2 = fwd_val(rs2_o, rd2_i, ex_fwd_i, mem_fwd_i);

    always_comb begin
        dec_valid = 1'b1;
        dec_wen   = 1'b0;
        dec_load  = 1'b0;
        dec_store = 1'b0;
        dec_halt  = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_jal    = 1'b0;
        dec_op    = alu_add;
        dec_op_b  = imm_i;
        case (opcode)
            opc_imm: begin
                use_rs1   = 1'b1;
                dec_wen   = 1'b1;
                dec_valid = (funct3 == 3'b000);   // addi only
            end
            opc_reg: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                dec_wen  = 1'b1;
                dec_op_b = src2;
                case ({inst[30], funct3})
                    4'b0_000: dec_op = alu_add;
                    4'b1_000: dec_op = alu_sub;
                    4'b0_111: dec_op = alu_and;
                    4'b0_110: dec_op = alu_or;
                    4'b0_100: dec_op = alu_xor;
                    4'b0_010: dec_op = alu_slt;
                    default:  dec_valid = 1'b0;
                endcase
            end
            opc_lui: begin
                dec_wen  = 1'b1;
                dec_op   = alu_pass_b;
                dec_op_b = imm_u;
            end
            opc_load: begin
                use_rs1   = 1'b1;
                dec_wen   = 1'b1;
                dec_load  = 1'b1;
                dec_valid = (funct3 == f3_dword);
            end
            opc_store: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                dec_store = 1'b1;
                dec_op_b  = imm_s;
                dec_valid = (funct3 == f3_dword);
            end
            opc_branch: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                is_beq    = (funct3 == 3'b000);
                is_bne    = (funct3 == 3'b001);
                dec_valid = is_beq || is_bne;
            end
            opc_jal: begin
                dec_wen  = 1'b1;
                is_jal   = 1'b1;
                dec_op   = alu_pass_b;
                dec_op_b = if_id_i.pc + xlen'(4);   // link value
            end
            opc_system: begin
                dec_halt  = (inst == inst_ebreak);
                dec_valid = 1'b0;                 // halts, writes nothing
            end
            default: dec_valid = 1'b0;            // unknown opcode or bubble
        endcase
    end

    assign ld_stall_o = ex_fwd_i.is_load && dec_valid &&
                        ((use_rs1 && fwd_hit(ex_fwd_i, rs1_o)) ||
                         (use_rs2 && fwd_hit(ex_fwd_i, rs2_o)));

    assign taken      = (is_beq && (src1 == src2)) || (is_bne && (src1 != src2)) || is_jal;
    assign redirect_o = taken && !ld_stall_o;     // wait for load data before resolving
    assign target_o   = if_id_i.pc + (is_jal ? imm_j : imm_b);

    assign id_ex_o.valid      = dec_valid;
    assign id_ex_o.pc         = if_id_i.pc;
    assign id_ex_o.op_a       = src1;
    assign id_ex_o.op_b       = dec_op_b;
    assign id_ex_o.store_data = src2;
    assign id_ex_o.alu_op     = dec_op;
    assign id_ex_o.reg_wen    = dec_valid && dec_wen && (rd != '0);
    assign id_ex_o.rd         = rd;
    assign id_ex_o.is_load    = dec_valid && dec_load;
    assign id_ex_o.is_store   = dec_valid && dec_store;
    assign id_ex_o.is_halt    = dec_halt;

endmodule

// ==== source/ex_stage.sv ====
// alu, address sum for ld/sd, store data pass-through and forwarding source
`timescale 1ns/10ps

module ex_stage (
    input  cpu_pkg::id_ex_t  id_ex_i,
    output cpu_pkg::ex_mem_t ex_mem_o,
    output cpu_pkg::fwd_t    ex_fwd_o
);
    import cpu_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;

    assign op_a = id_ex_i.op_a;
    assign op_b = id_ex_i.op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            alu_add: alu_res = op_a + op_b;   // also ld/sd address
            alu_sub: alu_res = op_a - op_b;
            alu_and: alu_res = op_a & op_b;
            alu_or:  alu_res = op_a | op_b;
            alu_xor: alu_res = op_a ^ op_b;
            alu_slt: alu_res = xlen'($signed(op_a) < $signed(op_b));
            default: alu_res = op_b;
        endcase
    end

    assign ex_mem_o.valid      = id_ex_i.valid;
    assign ex_mem_o.pc         = id_ex_i.pc;
    assign ex_mem_o.alu_res    = alu_res;
    assign ex_mem_o.store_data = id_ex_i.store_data;
    assign ex_mem_o.reg_wen    = id_ex_i.reg_wen;
    assign ex_mem_o.rd         = id_ex_i.rd;
    assign ex_mem_o.is_load    = id_ex_i.is_load;
    assign ex_mem_o.is_store   = id_ex_i.is_store;
    assign ex_mem_o.is_halt    = id_ex_i.is_halt;

    assign ex_fwd_o.valid   = id_ex_i.valid;
    assign ex_fwd_o.reg_wen = id_ex_i.reg_wen;
    assign ex_fwd_o.rd      = id_ex_i.rd;
    assign ex_fwd_o.value   = alu_res;
    assign ex_fwd_o.is_load = id_ex_i.is_load;   // decode stalls on this

endmodule

// ==== source/mem_stage.sv ====
// wishbone classic data master, busy generation and write-back value select
`timescale 1ns/10ps

module mem_stage (
    input  cpu_pkg::ex_mem_t ex_mem_i,
    output cpu_pkg::wb_req_t dwb_o,
    input  cpu_pkg::wb_rsp_t dwb_i,
    output logic             mem_busy_o,
    output cpu_pkg::mem_wb_t mem_wb_o,
    output cpu_pkg::fwd_t    mem_fwd_o
);

    logic access;

    assign access = ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store);

    // cyc/stb held with address and data until the ack edge
    assign dwb_o.cyc   = access;
    assign dwb_o.stb   = access;
    assign dwb_o.we    = ex_mem_i.is_store;
    assign dwb_o.adr   = ex_mem_i.alu_res;
    assign dwb_o.dat_w = ex_mem_i.store_data;

    assign mem_busy_o = access && !dwb_i.ack;   // pipeline moves on in the ack cycle

    assign mem_wb_o.valid   = ex_mem_i.valid;
    assign mem_wb_o.pc      = ex_mem_i.pc;
    assign mem_wb_o.wdata   = ex_mem_i.is_load ? dwb_i.dat_r : ex_mem_i.alu_res;
    assign mem_wb_o.reg_wen = ex_mem_i.reg_wen;
    assign mem_wb_o.rd      = ex_mem_i.rd;
    assign mem_wb_o.is_halt = ex_mem_i.is_halt;

    assign mem_fwd_o.valid   = ex_mem_i.valid;
    assign mem_fwd_o.reg_wen = ex_mem_i.reg_wen;
    assign mem_fwd_o.rd      = ex_mem_i.rd;
    assign mem_fwd_o.value   = mem_wb_o.wdata;     // load data valid in the ack cycle
    assign mem_fwd_o.is_load = ex_mem_i.is_load;

endmodule

// ==== source/cpu_top.sv ====
// five-stage rv64i core: stages, pipeline registers, register file and retire port
`timescale 1ns/10ps

module cpu_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    output logic [cpu_pkg::xlen-1:0] imem_addr_o,
    input  logic [31:0]              imem_data_i,
    output cpu_pkg::wb_req_t         dwb_o,
    input  cpu_pkg::wb_rsp_t         dwb_i,
    output cpu_pkg::retire_t         retire_o,
    output logic                     halt_o
);
    import cpu_pkg::*;

    if_id_t                if_id_d, if_id_q;
    id_ex_t                id_ex_d, id_ex_q;
    ex_mem_t               ex_mem_d, ex_mem_q;
    mem_wb_t               mem_wb_d, mem_wb_q;
    fwd_t                  ex_fwd, mem_fwd;
    logic [reg_addr_w-1:0] rs1, rs2;
    logic [xlen-1:0]       rd1, rd2, target;
    logic                  ld_stall, redirect, mem_busy;
    logic                  fe_stall, if_id_flush, id_ex_flush;

    assign fe_stall    = ld_stall || mem_busy;
    assign if_id_flush = redirect && !mem_busy;   // drop the wrong-path fetch
    assign id_ex_flush = ld_stall && !mem_busy;   // bubble behind the load

    if_stage u_if_stage (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(fe_stall), .halt_i(id_ex_d.is_halt),
        .redirect_i(redirect), .target_i(target), .imem_addr_o(imem_addr_o),
        .imem_data_i(imem_data_i), .if_id_o(if_id_d)
    );

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(fe_stall), .flush_i(if_id_flush),
        .d_i(if_id_d), .q_o(if_id_q)
    );

    id_stage u_id_stage (
        .if_id_i(if_id_q), .rs1_o(rs1), .rs2_o(rs2), .rd1_i(rd1), .rd2_i(rd2),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd), .id_ex_o(id_ex_d),
        .ld_stall_o(ld_stall), .redirect_o(redirect), .target_o(target)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n_i(rst_n_i), .ra1_i(rs1), .ra2_i(rs2), .rd1_o(rd1), .rd2_o(rd2),
        .we_i(mem_wb_q.reg_wen), .wa_i(mem_wb_q.rd), .wd_i(mem_wb_q.wdata)
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(mem_busy), .flush_i(id_ex_flush),
        .d_i(id_ex_d), .q_o(id_ex_q)
    );

    ex_stage u_ex_stage (
        .id_ex_i(id_ex_q), .ex_mem_o(ex_mem_d), .ex_fwd_o(ex_fwd)
    );

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(mem_busy), .flush_i(1'b0),
        .d_i(ex_mem_d), .q_o(ex_mem_q)
    );

    mem_stage u_mem_stage (
        .ex_mem_i(ex_mem_q), .dwb_o(dwb_o), .dwb_i(dwb_i), .mem_busy_o(mem_busy),
        .mem_wb_o(mem_wb_d), .mem_fwd_o(mem_fwd)
    );

    // halted core parks ebreak here so halt_o stays high
    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(mem_wb_q.is_halt), .flush_i(mem_busy),
        .d_i(mem_wb_d), .q_o(mem_wb_q)
    );

    assign retire_o.valid   = mem_wb_q.valid;
    assign retire_o.pc      = mem_wb_q.pc;
    assign retire_o.rd      = mem_wb_q.rd;
    assign retire_o.wdata   = mem_wb_q.wdata;
    assign retire_o.reg_wen = mem_wb_q.reg_wen;
    assign halt_o           = mem_wb_q.is_halt;

endmodule

// ==== sim/tb_cpu.sv ====
// testbench with clock, reset, instruction rom, wishbone memory model, case reader and checks
`timescale 1ns/10ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int reset_cycles    = 3;
    localparam int cycles_per_word = 20;
    localparam int max_wait        = 3;      // slave wait states 0..3
    localparam int rom_words       = 256;

    logic            clk          = 1'b0;
    logic            rst_n_i      = 1'b0;
    logic [xlen-1:0] imem_addr;
    logic [31:0]     imem_data    = '0;
    wb_req_t         dwb_req;
    wb_rsp_t         dwb_rsp      = '0;
    retire_t         retire;
    logic            halt;

    logic [31:0]     rom [rom_words];
    logic [xlen-1:0] dmem [logic [xlen-1:0]];
    retire_t         exp_retires [$];
    wb_req_t         exp_stores [$];
    int              n_prog       = 0;
    logic            cases_loaded = 1'b0;
    logic            halt_seen    = 1'b0;
    int              seed         = 32'hedcd79d9;
    logic            pending      = 1'b0;   // slave has picked a wait count
    int              wait_left    = 0;

    cpu_top u_dut (
        .clk(clk), .rst_n_i(rst_n_i), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .dwb_o(dwb_req), .dwb_i(dwb_rsp), .retire_o(retire), .halt_o(halt)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
        $display("Fail %s got %h expected %h", name, got, want);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_retire(input retire_t got);
        retire_t want;
        want = exp_retires.pop_front();
        if (got.pc !== want.pc) value_mismatch("retire_o.pc", got.pc, want.pc);
        if (got.reg_wen !== want.reg_wen) begin
            value_mismatch("retire_o.reg_wen", 64'(got.reg_wen), 64'(want.reg_wen));
        end
        if (want.reg_wen) begin
            if (got.rd !== want.rd) value_mismatch("retire_o.rd", 64'(got.rd), 64'(want.rd));
            if (got.wdata !== want.wdata) value_mismatch("retire_o.wdata", got.wdata, want.wdata);
        end
    endtask

    task automatic check_store(input wb_req_t got);
        wb_req_t want;
        if (exp_stores.size() == 0) begin
            abort_run("a store appeared on the data bus that the program does not contain");
        end else begin
            want = exp_stores.pop_front();
            if (got.adr !== want.adr) value_mismatch("dwb_o.adr", got.adr, want.adr);
            if (got.dat_w !== want.dat_w) value_mismatch("dwb_o.dat_w", got.dat_w, want.dat_w);
        end
    endtask

    function automatic logic [31:0] rom_word(input logic [xlen-1:0] adr);
        if (adr < 64'(rom_words * 4)) return rom[adr[9:2]];
        return '0;                             // zero word past the program decodes as bubble
    endfunction

    function automatic logic [xlen-1:0] fill_word(input logic [xlen-1:0] adr);
        return adr ^ 64'h5a5a_a5a5_0f0f_f0f0;  // untouched locations
    endfunction

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  tag;
        logic [63:0] f1, f2, f3;
        retire_t     r;
        wb_req_t     s;
        foreach (rom[i]) begin
            rom[i] = '0;
        end
        fd = $fopen("sim/cpu_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the case file sim/cpu_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h %h", tag, f1, f2, f3);
                case (tag)
                    "p": begin
                        rom[n_prog] = f1[31:0];
                        n_prog++;
                    end
                    "m": dmem[f1] = f2;
                    "r": begin
                        if (n < 4) abort_run("a retire line in the case file is short");
                        r.valid   = 1'b1;
                        r.pc      = f1;
                        r.rd      = f2[reg_addr_w-1:0];
                        r.reg_wen = (f2 != '0);    // rd 0 means nothing is written
                        r.wdata   = f3;
                        exp_retires.push_back(r);
                    end
                    "s": begin
                        s.cyc   = 1'b1;
                        s.stb   = 1'b1;
                        s.we    = 1'b1;
                        s.adr   = f1;
                        s.dat_w = f2;
                        exp_stores.push_back(s);
                    end
                    default: ;                     // comment or blank line
                endcase
            end
            $fclose(fd);
            cases_loaded = 1'b1;
        end
    endtask

    task automatic serve_access();
        if (dwb_req.we) begin
            check_store(dwb_req);
            dmem[dwb_req.adr] = dwb_req.dat_w;
        end else begin
            dwb_rsp.dat_r <= dmem.exists(dwb_req.adr) ? dmem[dwb_req.adr] : fill_word(dwb_req.adr);
        end
        dwb_rsp.ack <= 1'b1;
    endtask

    // rom and wishbone slave driven on the falling edge
    always @(negedge clk) begin
        imem_data   <= rom_word(imem_addr);
        dwb_rsp.ack <= 1'b0;
        if (rst_n_i && dwb_req.cyc && dwb_req.stb) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $unsigned($random(seed)) % (max_wait + 1);
            end
            if (wait_left == 0) begin
                pending = 1'b0;
                serve_access();
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // retire and halt monitor
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (halt_seen && !halt) abort_run("halt_o dropped while the core was halted");
            if (retire.valid) begin
                if (halt_seen) begin
                    abort_run("an instruction retired after halt_o rose");
                end else if (exp_retires.size() == 0) begin
                    abort_run("more instructions retired than the program expects");
                end else begin
                    check_retire(retire);
                end
            end
            if (halt && !halt_seen) begin
                halt_seen = 1'b1;
                if (exp_retires.size() != 0) begin
                    abort_run("halt_o rose before all expected instructions retired");
                end
            end
        end
    end

    initial begin
        int limit;
        wait (cases_loaded);
        limit = reset_cycles + n_prog * cycles_per_word + 4 * max_wait;
        repeat (limit) @(posedge clk);
        $display("timeout: the core did not halt within %0d cycles", limit);
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        read_cases();
        repeat (reset_cycles) @(negedge clk);
        rst_n_i <= 1'b1;
        wait (halt_seen);
        repeat (4) @(negedge clk);             // catch late retires
        if (exp_stores.size() != 0) begin
            abort_run("an expected store never appeared on the data bus");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== sim/cpu_cases.txt ====
# p <instruction word> | m <address> <doubleword> | r <pc> <rd> <rd value> | s <address> <data>
# all values hex, r and s lines in program order, rd 0 means no register write
m 0000000000000100 1122334455667788
m 0000000000000108 deadbeefdeadbeef
p 00500093 addi x1 x0 5
p ffd00113 addi x2 x0 -3
p 002081b3 add x3 x1 x2
p 40208233 sub x4 x1 x2
p 0020f2b3 and x5 x1 x2
p 0020e333 or x6 x1 x2
p 0020c3b3 xor x7 x1 x2
p 00112433 slt x8 x2 x1
p 123454b7 lui x9 0x12345
p 00700013 addi x0 x0 7
p 00048533 add x10 x9 x0
p 10003583 ld x11 0x100(x0)
p 00158633 add x12 x11 x1
p 10c03423 sd x12 0x108(x0)
p 10803683 ld x13 0x108(x0)
p 00c68463 beq x13 x12 +8
p 00100713 addi x14 x0 1 skipped
p 00109463 bne x1 x1 +8
p 7ff00793 addi x15 x0 0x7ff
p 00179463 bne x15 x1 +8
p 00200713 addi x14 x0 2 skipped
p 0080086f jal x16 +8
p 00300713 addi x14 x0 3 skipped
p 00208463 beq x1 x2 +8
p 1101b723 sd x16 0x10e(x3)
p 00100073 ebreak
r 00 01 0000000000000005
r 04 02 fffffffffffffffd
r 08 03 0000000000000002
r 0c 04 0000000000000008
r 10 05 0000000000000005
r 14 06 fffffffffffffffd
r 18 07 fffffffffffffff8
r 1c 08 0000000000000001
r 20 09 0000000012345000
r 24 00 0000000000000000
r 28 0a 0000000012345000
r 2c 0b 1122334455667788
r 30 0c 112233445566778d
r 34 00 0000000000000000
r 38 0d 112233445566778d
r 3c 00 0000000000000000
r 44 00 0000000000000000
r 48 0f 00000000000007ff
r 4c 00 0000000000000000
r 54 10 0000000000000058
r 5c 00 0000000000000000
r 60 00 0000000000000000
s 0000000000000108 112233445566778d
s 0000000000000110 0000000000000058

// ==== sim.f ====
source/cpu_pkg.sv
source/stage_reg.sv
source/if_stage.sv
source/reg_file.sv
source/id_stage.sv
source/ex_stage.sv
source/mem_stage.sv
source/cpu_top.sv
sim/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it, the exit status follows the simulation
cd "$(dirname "$0")" &&
    verilator --binary --timing --top-module tb_cpu -f sim.f -o tb_cpu &&
    ./obj_dir/tb_cpu ||
    exit 1
